// File: tb.f
design/sdadc_pkg.sv
design/sdadc_regs.sv
design/sinc3_decimator.sv
design/sample_trim.sv
design/sample_fifo.sv
design/sdadc_top.sv
testbench/tb_sdadc.sv

// File: Makefile
TOP = tb_sdadc

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_sdadc.sv
`timescale 1ns/100ps

module tb_sdadc
    import sdadc_pkg::*;
();

    localparam int CLK_NS = 4;
    localparam int EN_DIV = 4;                          // One modulator bit every fourth cycle.
    localparam int FAST_WORDS = 10 + 15 + 9;            // Words of the tests that run at OSR 32.
    localparam int RATIO_BITS = 4 * (32 + 64 + 128 + 256);
    localparam int WATCHDOG_NS = (FAST_WORDS * 32 + RATIO_BITS) * EN_DIV * CLK_NS * 3 / 2;

    localparam logic [1:0] PAT_ZEROS = 2'd0;
    localparam logic [1:0] PAT_ONES  = 2'd1;
    localparam logic [1:0] PAT_ALT   = 2'd2;            // No signal at all, like an idle line.
    localparam logic [1:0] PAT_3Q    = 2'd3;

    typedef struct packed
    {
        logic        chk;
        logic        err;
        logic [31:0] data;
    } rd_expect_t;

    typedef struct packed
    {
        logic chk;
        logic val;
    } irq_expect_t;

    logic        word_clk = 1'b0;
    logic        reset;
    logic        mdata = 1'b0;
    logic        mclk_en = 1'b0;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        irq;
    rd_expect_t  rd_exp;
    irq_expect_t irq_exp;
    logic [1:0]  div_cnt = 2'd0;
    logic [7:0]  bit_idx = 8'd0;
    logic [1:0]  pattern = PAT_ZEROS;
    logic        phase = 1'b0;
    int          seed = 32'h696a_bfa0;
    int          err_cnt = 0;
    int          err_base = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    always #(CLK_NS / 2) word_clk = ~word_clk;

    always @(posedge word_clk)
    begin
        div_cnt <= div_cnt + 2'd1;
        mclk_en <= (div_cnt == 2'd3);
        if (div_cnt == 2'd3)
        begin
            bit_idx <= bit_idx + 8'd1;
            case (pattern)
                PAT_ONES: mdata <= 1'b1;
                PAT_ALT:  mdata <= bit_idx[0] ^ phase;
                PAT_3Q:   mdata <= (bit_idx[1:0] != 2'd3);  // Density 3/4.
                default:  mdata <= 1'b0;
            endcase
        end
    end

    sdadc_top i_sdadc_top (
        .word_clk  (word_clk),
        .reset_i   (reset),
        .mdata_i   (mdata),
        .mclk_en_i (mclk_en),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .irq_o     (irq)
    );

    a_read_data: assert property (@(posedge word_clk)
        (rd_exp.chk && psel && penable) |-> (prdata == rd_exp.data && pslverr == rd_exp.err))
    else
    begin
        err_cnt++;
        $display("Error at %0d ns: access to 0x%02h gave 0x%08h err %0b, expected 0x%08h err %0b",
                 $time, $sampled(paddr), $sampled(prdata), $sampled(pslverr),
                 $sampled(rd_exp.data), $sampled(rd_exp.err));
    end

    a_irq_level: assert property (@(posedge word_clk) irq_exp.chk |-> (irq == irq_exp.val))
    else
    begin
        err_cnt++;
        $display("Error at %0d ns: irq_o is %0b, expected %0b", $time, $sampled(irq),
                 $sampled(irq_exp.val));
    end

    a_ready_high: assert property (@(posedge word_clk) disable iff (reset) pready)
    else
    begin
        err_cnt++;
        $display("The APB ready output dropped at %0d ns.", $time);
    end

    task automatic apb_access(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
                              input rd_expect_t exp_in, output logic [31:0] rdata);
        @(posedge word_clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        rd_exp  <= exp_in;
        @(posedge word_clk);
        penable <= 1'b1;
        @(negedge word_clk);
        rdata = prdata;
        @(posedge word_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        rd_exp  <= '0;
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        apb_access(1'b1, addr, wdata, '0, unused);
    endtask

    task automatic read_reg(input logic [4:0] addr, output logic [31:0] rdata);
        apb_access(1'b0, addr, 32'd0, '0, rdata);
    endtask

    task automatic check_reg(input logic [4:0] addr, input logic [31:0] value);
        logic [31:0] unused;
        apb_access(1'b0, addr, 32'd0, '{chk: 1'b1, err: 1'b0, data: value}, unused);
    endtask

    task automatic start_stream(input logic [1:0] pat, input osr_sel_e osr, input logic irq_en);
        int rnd;
        write_reg(REG_CTRL, 32'd0);                     // Disabled, the filter state is cleared.
        rnd = $random(seed);
        phase   <= rnd[0];
        pattern <= pat;
        write_reg(REG_CTRL, {27'd0, irq_en, 1'b1, osr, 1'b1});
    endtask

    task automatic wait_level(input int n);
        logic [31:0] stat;
        stat = 32'd0;
        while (int'(stat[3:0]) < n)
        begin
            read_reg(REG_STATUS, stat);
        end
    endtask

    task automatic collect_words(input int total, input int skip, input logic [31:0] value);
        logic [31:0] unused;
        wait_level(total);
        for (int i = 0; i < total; i++)
        begin
            if (i < skip)
            begin
                read_reg(REG_DATA, unused);             // Filter transients after a restart.
            end
            else
            begin
                check_reg(REG_DATA, value);
            end
        end
    endtask

    task automatic finish_test(input string name);
        @(posedge word_clk);
        tests_run++;
        if (err_cnt != err_base)
        begin
            tests_failed++;
            $display("Test %0d %s: failed, %0d errors", tests_run, name, err_cnt - err_base);
        end
        else
        begin
            $display("Test %0d %s: passed", tests_run, name);
        end
        err_base = err_cnt;
    endtask

    initial
    begin
        logic [31:0] rdata;
        int          wait_cnt;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 5'd0;
        pwdata  = 32'd0;
        rd_exp  = '0;
        irq_exp = '0;
        repeat (16) @(posedge word_clk);
        reset <= 1'b0;

        check_reg(REG_GAIN, 32'h0000_4000);
        check_reg(REG_CTRL, 32'd0);
        write_reg(REG_CTRL, 32'h0000_0016);
        check_reg(REG_CTRL, 32'h0000_0016);
        write_reg(REG_OFFSET, 32'h0000_abcd);
        check_reg(REG_OFFSET, 32'h0000_abcd);
        write_reg(REG_GAIN, 32'h0000_1234);
        check_reg(REG_GAIN, 32'h0000_1234);
        apb_access(1'b1, 5'h14, 32'hffff_ffff, '{chk: 1'b1, err: 1'b1, data: 32'd0}, rdata);
        apb_access(1'b0, 5'h14, 32'd0, '{chk: 1'b1, err: 1'b1, data: 32'd0}, rdata);
        write_reg(REG_CTRL, 32'd0);
        write_reg(REG_OFFSET, 32'd0);
        write_reg(REG_GAIN, 32'h0000_4000);
        finish_test("register access");

        start_stream(PAT_ONES, OSR_32, 1'b0);
        collect_words(5, 2, 32'h0000_7fff);
        start_stream(PAT_ZEROS, OSR_32, 1'b0);
        collect_words(5, 2, 32'hffff_8000);
        finish_test("full scale");

        start_stream(PAT_ALT, OSR_32, 1'b0);
        collect_words(5, 2, 32'd0);
        write_reg(REG_OFFSET, 32'd100);
        start_stream(PAT_ALT, OSR_32, 1'b0);
        collect_words(5, 2, 32'd100);
        write_reg(REG_GAIN, 32'h0000_2000);             // Half of unity.
        start_stream(PAT_ALT, OSR_32, 1'b0);
        collect_words(5, 2, 32'd50);
        write_reg(REG_OFFSET, 32'd0);
        write_reg(REG_GAIN, 32'h0000_4000);
        finish_test("trim");

        for (int r = 0; r < 4; r++)
        begin
            start_stream(PAT_3Q, osr_sel_e'(r[1:0]), 1'b0);
            collect_words(4, 2, 32'd16384);
        end
        finish_test("ratios");

        start_stream(PAT_ONES, OSR_32, 1'b1);
        wait_cnt = 0;
        while (!irq && wait_cnt < 2 * 32 * EN_DIV)
        begin
            @(negedge word_clk);
            wait_cnt++;
        end
        if (!irq)
        begin
            err_cnt++;
            $display("The interrupt did not rise while a word was waiting.");
        end
        @(posedge word_clk);
        irq_exp <= '{chk: 1'b1, val: 1'b1};
        check_reg(REG_STATUS, 32'h0000_0001);
        irq_exp <= '0;
        rdata = 32'd0;
        while (!rdata[6])
        begin
            read_reg(REG_STATUS, rdata);
        end
        write_reg(REG_CTRL, 32'h0000_0010);             // Stop the stream, keep irq_en.
        check_reg(REG_STATUS, 32'h0000_0068);
        for (int i = 0; i < FIFO_DEPTH; i++)
        begin
            read_reg(REG_DATA, rdata);
        end
        repeat (2) @(posedge word_clk);
        irq_exp <= '{chk: 1'b1, val: 1'b0};
        @(posedge word_clk);
        irq_exp <= '0;
        check_reg(REG_STATUS, 32'h0000_0050);
        write_reg(REG_STATUS, 32'h0000_0040);
        check_reg(REG_STATUS, 32'h0000_0010);
        finish_test("fifo and interrupt");

        $display("Tests run: %0d, passed: %0d, failed: %0d", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (tests_failed == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("The watchdog expired after %0d ns before the tests finished.", WATCHDOG_NS);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: design/sdadc_top.sv
`timescale 1ns/100ps

module sdadc_top
    import sdadc_pkg::*;
(
    input  logic        word_clk,
    input  logic        reset_i,
    input  logic        mdata_i,
    input  logic        mclk_en_i,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [4:0]  paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    output logic        irq_o
);

    sdadc_cfg_t          cfg;
    fifo_stat_t          fifo_stat;
    logic [SAMPLE_W-1:0] fifo_head;
    logic                fifo_pop;
    logic                fifo_clear;
    logic                ovf_clear;
    logic                dec_valid;
    logic [SAMPLE_W-1:0] dec_sample;
    logic                trim_valid;
    logic [SAMPLE_W-1:0] trim_sample;

    assign pready_o = 1'b1;                             // Every transfer completes at once.

    sdadc_regs i_sdadc_regs (
        .word_clk     (word_clk),
        .reset_i      (reset_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pslverr_o    (pslverr_o),
        .fifo_stat_i  (fifo_stat),
        .fifo_head_i  (fifo_head),
        .cfg_o        (cfg),
        .fifo_pop_o   (fifo_pop),
        .fifo_clear_o (fifo_clear),
        .ovf_clear_o  (ovf_clear),
        .irq_o        (irq_o)
    );

    sinc3_decimator i_sinc3_decimator (
        .word_clk     (word_clk),
        .reset_i      (reset_i),
        .mdata_i      (mdata_i),
        .mclk_en_i    (mclk_en_i),
        .cfg_i        (cfg),
        .dec_valid_o  (dec_valid),
        .dec_sample_o (dec_sample)
    );

    sample_trim i_sample_trim (
        .word_clk      (word_clk),
        .reset_i       (reset_i),
        .dec_valid_i   (dec_valid),
        .dec_sample_i  (dec_sample),
        .cfg_i         (cfg),
        .trim_valid_o  (trim_valid),
        .trim_sample_o (trim_sample)
    );

    sample_fifo i_sample_fifo (
        .word_clk    (word_clk),
        .reset_i     (reset_i),
        .push_i      (trim_valid),
        .push_data_i (trim_sample),
        .pop_i       (fifo_pop),
        .clear_i     (fifo_clear),
        .ovf_clear_i (ovf_clear),
        .head_o      (fifo_head),
        .stat_o      (fifo_stat)
    );

endmodule

// File: design/sample_fifo.sv
`timescale 1ns/100ps

module sample_fifo
    import sdadc_pkg::*;
(
    input  logic                word_clk,
    input  logic                reset_i,
    input  logic                push_i,
    input  logic [SAMPLE_W-1:0] push_data_i,
    input  logic                pop_i,
    input  logic                clear_i,
    input  logic                ovf_clear_i,
    output logic [SAMPLE_W-1:0] head_o,
    output fifo_stat_t          stat_o
);

    logic [SAMPLE_W-1:0]           mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [3:0]                    level;
    logic                          overflow;
    logic                          empty;
    logic                          full;
    logic                          do_push;
    logic                          do_pop;

    assign empty   = (level == 4'd0);
    assign full    = (level == 4'(FIFO_DEPTH));
    assign do_pop  = pop_i && !empty;
    assign do_push = push_i && (!full || do_pop);       // A pop frees the slot this cycle.

    always_ff @(posedge word_clk or posedge reset_i)
    begin
        if (reset_i)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            level    <= '0;
            overflow <= 1'b0;
        end
        else if (clear_i)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            level    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop)
            begin
                level <= level + 4'd1;
            end
            else if (do_pop && !do_push)
            begin
                level <= level - 4'd1;
            end
            if (push_i && !do_push)
            begin
                overflow <= 1'b1;
            end
            else if (ovf_clear_i)
            begin
                overflow <= 1'b0;
            end
        end
    end

    always_ff @(posedge word_clk)
    begin
        if (do_push && !clear_i)
        begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    assign head_o = mem[rd_ptr];

    always_comb
    begin
        stat_o.level    = level;
        stat_o.empty    = empty;
        stat_o.full     = full;
        stat_o.overflow = overflow;
    end

    a_level_bound: assert property (@(posedge word_clk) disable iff (reset_i)
        level <= 4'(FIFO_DEPTH));

endmodule

// File: design/sample_trim.sv
`timescale 1ns/100ps

module sample_trim
    import sdadc_pkg::*;
(
    input  logic                word_clk,
    input  logic                reset_i,
    input  logic                dec_valid_i,
    input  logic [SAMPLE_W-1:0] dec_sample_i,
    input  sdadc_cfg_t          cfg_i,
    output logic                trim_valid_o,
    output logic [SAMPLE_W-1:0] trim_sample_o
);

    logic signed [17:0]        sum;
    logic signed [34:0]        prod;
    logic signed [20:0]        scaled;
    logic [SAMPLE_W-1:0]       sat_sample;

    // Two extra bits keep the offset add from wrapping.
    assign sum  = $signed(dec_sample_i) + $signed(cfg_i.offset);
    assign prod = sum * $signed({1'b0, cfg_i.gain});

    assign scaled = prod[GAIN_FRAC +: 21];

    always_comb
    begin
        if (&scaled[20:SAMPLE_W-1] || ~|scaled[20:SAMPLE_W-1])
        begin
            sat_sample = scaled[SAMPLE_W-1:0];
        end
        else
        begin
            sat_sample = {scaled[20], {(SAMPLE_W-1){~scaled[20]}}};
        end
    end

    always_ff @(posedge word_clk or posedge reset_i)
    begin
        if (reset_i)
        begin
            trim_valid_o <= 1'b0;
        end
        else
        begin
            trim_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge word_clk)
    begin
        if (dec_valid_i)
        begin
            trim_sample_o <= sat_sample;
        end
    end

endmodule

// File: design/sinc3_decimator.sv
`timescale 1ns/100ps

module sinc3_decimator
    import sdadc_pkg::*;
(
    input  logic                word_clk,
    input  logic                reset_i,
    input  logic                mdata_i,
    input  logic                mclk_en_i,
    input  sdadc_cfg_t          cfg_i,
    output logic                dec_valid_o,
    output logic [SAMPLE_W-1:0] dec_sample_o
);

    osr_sel_e                osr_q;
    logic                    flush;
    logic                    strobe;
    logic                    word_end;
    logic [7:0]              ratio_cnt;
    logic [7:0]              ratio_last;
    logic [3:0]              shift;
    logic signed [ACC_W-1:0] x_in;
    logic signed [ACC_W-1:0] int1, int2, int3;
    logic signed [ACC_W-1:0] int1_n, int2_n, int3_n;
    logic signed [ACC_W-1:0] int3_d, c1_d, c2_d;
    logic signed [ACC_W-1:0] c1, c2, c3;
    logic signed [ACC_W-1:0] c3_shift;
    logic [SAMPLE_W-1:0]     sat_sample;

    // A change of ratio restarts the filter from zero.
    assign flush  = !cfg_i.enable || (cfg_i.osr_sel != osr_q);
    assign strobe = mclk_en_i && cfg_i.enable;

    always_comb
    begin
        case (cfg_i.osr_sel)
            OSR_32:  begin ratio_last = 8'd31;  shift = 4'd0; end
            OSR_64:  begin ratio_last = 8'd63;  shift = 4'd3; end
            OSR_128: begin ratio_last = 8'd127; shift = 4'd6; end
            default: begin ratio_last = 8'd255; shift = 4'd9; end
        endcase
    end

    assign word_end = (ratio_cnt == ratio_last);

    // A one counts as +1 and a zero as -1.
    assign x_in = {{(ACC_W-1){~mdata_i}}, 1'b1};

    assign int1_n = int1 + x_in;
    assign int2_n = int2 + int1_n;
    assign int3_n = int3 + int2_n;

    assign c1 = int3_n - int3_d;
    assign c2 = c1 - c1_d;
    assign c3 = c2 - c2_d;

    assign c3_shift = c3 >>> shift;                     // Full scale becomes 2^15.

    always_comb
    begin
        if (&c3_shift[ACC_W-1:SAMPLE_W-1] || ~|c3_shift[ACC_W-1:SAMPLE_W-1])
        begin
            sat_sample = c3_shift[SAMPLE_W-1:0];
        end
        else
        begin
            sat_sample = {c3_shift[ACC_W-1], {(SAMPLE_W-1){~c3_shift[ACC_W-1]}}};
        end
    end

    always_ff @(posedge word_clk or posedge reset_i)
    begin
        if (reset_i)
        begin
            osr_q       <= OSR_32;
            ratio_cnt   <= '0;
            int1        <= '0;
            int2        <= '0;
            int3        <= '0;
            int3_d      <= '0;
            c1_d        <= '0;
            c2_d        <= '0;
            dec_valid_o <= 1'b0;
        end
        else
        begin
            osr_q       <= cfg_i.osr_sel;
            dec_valid_o <= 1'b0;
            if (flush)
            begin
                ratio_cnt <= '0;
                int1      <= '0;
                int2      <= '0;
                int3      <= '0;
                int3_d    <= '0;
                c1_d      <= '0;
                c2_d      <= '0;
            end
            else if (strobe)
            begin
                int1 <= int1_n;
                int2 <= int2_n;
                int3 <= int3_n;
                if (word_end)
                begin
                    ratio_cnt   <= '0;
                    int3_d      <= int3_n;
                    c1_d        <= c1;
                    c2_d        <= c2;
                    dec_valid_o <= 1'b1;
                end
                else
                begin
                    ratio_cnt <= ratio_cnt + 8'd1;
                end
            end
        end
    end

    always_ff @(posedge word_clk)
    begin
        if (strobe && word_end && !flush)
        begin
            dec_sample_o <= sat_sample;
        end
    end

    a_valid_single: assert property (@(posedge word_clk) disable iff (reset_i)
        dec_valid_o |=> !dec_valid_o);

endmodule

// File: design/sdadc_regs.sv
`timescale 1ns/100ps

module sdadc_regs
    import sdadc_pkg::*;
(
    input  logic                word_clk,
    input  logic                reset_i,
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  logic [4:0]          paddr_i,
    input  logic [31:0]         pwdata_i,
    output logic [31:0]         prdata_o,
    output logic                pslverr_o,
    input  fifo_stat_t          fifo_stat_i,
    input  logic [SAMPLE_W-1:0] fifo_head_i,
    output sdadc_cfg_t          cfg_o,
    output logic                fifo_pop_o,
    output logic                fifo_clear_o,
    output logic                ovf_clear_o,
    output logic                irq_o
);

    logic                access;
    logic                wr_en;
    logic                rd_en;
    logic                addr_hit;
    logic [31:0]         rd_data;
    logic                ctrl_enable;
    osr_sel_e            ctrl_osr;
    logic                ctrl_irq_en;
    logic [SAMPLE_W-1:0] offset_q;
    logic [SAMPLE_W-1:0] gain_q;

    assign access = psel_i && penable_i;
    assign wr_en  = access && pwrite_i && addr_hit;
    assign rd_en  = access && !pwrite_i;

    always_comb
    begin
        addr_hit = 1'b1;
        rd_data  = '0;
        case (paddr_i)
            REG_CTRL:   rd_data[4:0] = {ctrl_irq_en, 1'b0, ctrl_osr, ctrl_enable};
            REG_OFFSET: rd_data[SAMPLE_W-1:0] = offset_q;
            REG_GAIN:   rd_data[SAMPLE_W-1:0] = gain_q;
            REG_STATUS: rd_data[6:0] = {fifo_stat_i.overflow, fifo_stat_i.full,
                                        fifo_stat_i.empty, fifo_stat_i.level};
            REG_DATA:
            begin
                if (!fifo_stat_i.empty)
                begin
                    rd_data = {{(32-SAMPLE_W){fifo_head_i[SAMPLE_W-1]}}, fifo_head_i};
                end
            end
            default:    addr_hit = 1'b0;
        endcase
    end

    assign prdata_o  = rd_en ? rd_data : '0;
    assign pslverr_o = access && !addr_hit;

    // The FIFO acts on the same edge that ends the access phase.
    assign fifo_pop_o   = rd_en && (paddr_i == REG_DATA) && !fifo_stat_i.empty;
    assign fifo_clear_o = wr_en && (paddr_i == REG_CTRL) && pwdata_i[3];
    assign ovf_clear_o  = wr_en && (paddr_i == REG_STATUS) && pwdata_i[6];

    always_ff @(posedge word_clk or posedge reset_i)
    begin
        if (reset_i)
        begin
            ctrl_enable <= 1'b0;
            ctrl_osr    <= OSR_32;
            ctrl_irq_en <= 1'b0;
            offset_q    <= '0;
            gain_q      <= GAIN_RESET;
            irq_o       <= 1'b0;
        end
        else
        begin
            if (wr_en && (paddr_i == REG_CTRL))
            begin
                ctrl_enable <= pwdata_i[0];
                ctrl_osr    <= osr_sel_e'(pwdata_i[2:1]);
                ctrl_irq_en <= pwdata_i[4];
            end
            if (wr_en && (paddr_i == REG_OFFSET))
            begin
                offset_q <= pwdata_i[SAMPLE_W-1:0];
            end
            if (wr_en && (paddr_i == REG_GAIN))
            begin
                gain_q <= pwdata_i[SAMPLE_W-1:0];
            end
            irq_o <= ctrl_irq_en && !fifo_stat_i.empty;
        end
    end

    always_comb
    begin
        cfg_o.enable  = ctrl_enable;
        cfg_o.osr_sel = ctrl_osr;
        cfg_o.irq_en  = ctrl_irq_en;
        cfg_o.offset  = offset_q;
        cfg_o.gain    = gain_q;
    end

    // Zero wait states, so every access phase follows exactly one setup phase.
    a_apb_setup: assert property (@(posedge word_clk) disable iff (reset_i)
        (psel_i && penable_i) |-> $past(psel_i && !penable_i));

endmodule

// File: design/sdadc_pkg.sv
package sdadc_pkg;

    localparam int FIFO_DEPTH = 8;
    localparam int SAMPLE_W = 16;
    localparam int ACC_W = 26;                          // Holds +/-256^3 with sign.

    localparam logic [4:0] REG_CTRL   = 5'h00;
    localparam logic [4:0] REG_OFFSET = 5'h04;
    localparam logic [4:0] REG_GAIN   = 5'h08;
    localparam logic [4:0] REG_STATUS = 5'h0C;
    localparam logic [4:0] REG_DATA   = 5'h10;

    // Gain is Q2.14, so 0x4000 is a gain of one.
    localparam int GAIN_FRAC = 14;
    localparam logic [SAMPLE_W-1:0] GAIN_RESET = 16'h4000;

    typedef enum logic [1:0]
    {
        OSR_32  = 2'd0,
        OSR_64  = 2'd1,
        OSR_128 = 2'd2,
        OSR_256 = 2'd3
    } osr_sel_e;

    typedef struct packed
    {
        logic                enable;
        osr_sel_e            osr_sel;
        logic                irq_en;
        logic [SAMPLE_W-1:0] offset;                    // Two's complement.
        logic [SAMPLE_W-1:0] gain;
    } sdadc_cfg_t;

    typedef struct packed
    {
        logic [3:0] level;
        logic       empty;
        logic       full;
        logic       overflow;
    } fifo_stat_t;

endpackage
